// ==== verilog/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

    // ============================================================
    // Opcodes and shift types in ARM data-processing encoding
    // ============================================================
    typedef enum logic [3:0] {
        OP_AND = 4'd0,
        OP_EOR = 4'd1,
        OP_SUB = 4'd2,
        OP_ADD = 4'd4,
        OP_ADC = 4'd5,
        OP_SBC = 4'd6,
        OP_ORR = 4'd12,
        OP_MOV = 4'd13,
        OP_BIC = 4'd14
    } alu_op_e;                                 // Other codes unsupported

    typedef enum logic [1:0] {
        SH_LSL = 2'd0,
        SH_LSR = 2'd1,
        SH_ASR = 2'd2,
        SH_ROR = 2'd3
    } shift_e;

    // Instruction word field positions
    localparam int OP2_MSB = 11;
    localparam int OP2_LSB = 0;
    localparam int S_BIT   = 20;                // Set condition codes
    localparam int OPC_MSB = 24;
    localparam int OPC_LSB = 21;
    localparam int IMM_BIT = 25;                // Operand 2 is immediate

    // ============================================================
    // Operand 2 field decoded two ways from the same 12 bits
    // ============================================================
    typedef struct packed {
        logic [3:0] rot;                        // Rotate right by 2*rot
        logic [7:0] imm8;
    } op2_imm_t;

    typedef struct packed {
        logic [4:0] shift_imm;                  // Amount from instruction
        shift_e     stype;
        logic       reg_shift;                  // Amount from Rs instead
        logic [3:0] unused;
    } op2_reg_t;

    typedef union packed {
        op2_imm_t imm;
        op2_reg_t rg;
    } op2_field_u;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } nzcv_t;

endpackage

`default_nettype wire

// ==== verilog/alu_regmap_pkg.sv ====
`default_nettype none

package alu_regmap_pkg;

    localparam int WB_ADR_W = 5;                // Byte address width

    // Register byte offsets with the low two bits ignored on decode
    localparam logic [WB_ADR_W-1:0] REG_INSTR  = 5'h00;  // Write issues
    localparam logic [WB_ADR_W-1:0] REG_RN     = 5'h04;
    localparam logic [WB_ADR_W-1:0] REG_RM     = 5'h08;
    localparam logic [WB_ADR_W-1:0] REG_RS     = 5'h0C;  // Bits 7:0 used
    localparam logic [WB_ADR_W-1:0] REG_FLAGS  = 5'h10;
    localparam logic [WB_ADR_W-1:0] REG_RESULT = 5'h14;  // Read only
    localparam logic [WB_ADR_W-1:0] REG_STATUS = 5'h18;  // Read only

    localparam int FLAGS_LSB   = 28;            // NZCV in bits 31:28
    localparam int STATUS_BUSY = 0;

endpackage

`default_nettype wire

// ==== verilog/alu_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_regs
    import alu_pkg::*;
    import alu_regmap_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [WB_ADR_W-1:0] wb_adr,
    input  logic [31:0]         wb_dat_w,
    input  logic [3:0]          wb_sel,
    output logic [31:0]         wb_dat_r,
    output logic                wb_ack,
    output logic                start,          // One-cycle issue pulse
    output alu_op_e             op,
    output logic                s,
    output logic                imm,
    output op2_field_u          op2,
    output logic [31:0]         rn,
    output logic [31:0]         rm,
    output logic [7:0]          rs_amt,
    output nzcv_t               flags_in,
    input  logic                done,           // From second execute stage
    input  logic [31:0]         result,
    input  nzcv_t               flags_out
);

    logic [31:0]         instr_r;
    logic [31:0]         rn_r;
    logic [31:0]         rm_r;
    logic [31:0]         rs_r;
    nzcv_t               flags_r;
    logic [31:0]         result_r;
    logic                busy;              // Instruction in flight
    logic                bus_req;           // Access accepted this edge
    logic [WB_ADR_W-1:0] adr_w;             // Word-aligned address
    logic [31:0]         rd_data;
    logic [31:0]         flags_word;

    // Byte-lane merge for partial writes
    function automatic logic [31:0] byte_merge(
        input logic [31:0] old_val,
        input logic [31:0] new_val,
        input logic [3:0]  sel
    );
        logic [31:0] merged;
        merged = old_val;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                merged[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return merged;
    endfunction

    // ============================================================
    // Bus decode and read mux
    // ============================================================
    assign adr_w   = {wb_adr[WB_ADR_W-1:2], 2'b00};
    assign bus_req = wb_cyc && wb_stb && !wb_ack && !busy;  // Stall while busy

    assign flags_word = byte_merge({flags_r, 28'd0}, wb_dat_w, wb_sel);

    always_comb begin
        rd_data = '0;                       // Unmapped reads zero
        case (adr_w)
            REG_INSTR:  rd_data = instr_r;
            REG_RN:     rd_data = rn_r;
            REG_RM:     rd_data = rm_r;
            REG_RS:     rd_data = rs_r;
            REG_FLAGS:  rd_data[FLAGS_LSB +: 4] = flags_r;
            REG_RESULT: rd_data = result_r;
            REG_STATUS: rd_data[STATUS_BUSY] = busy;
            default:    rd_data = '0;
        endcase
    end

    // ============================================================
    // Register file, ack and issue control
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
            busy     <= 1'b0;
            start    <= 1'b0;
            instr_r  <= '0;
            rn_r     <= '0;
            rm_r     <= '0;
            rs_r     <= '0;
            flags_r  <= '0;
            result_r <= '0;
        end else begin
            wb_ack <= 1'b0;                 // Single-cycle ack
            start  <= 1'b0;
            if (done) begin                 // Completion from execute path
                result_r <= result;
                flags_r  <= flags_out;
                busy     <= 1'b0;
            end
            if (bus_req) begin
                wb_ack   <= 1'b1;
                wb_dat_r <= rd_data;
                if (wb_we) begin
                    case (adr_w)
                        REG_INSTR: begin
                            instr_r <= byte_merge(instr_r, wb_dat_w, wb_sel);
                            busy    <= 1'b1;     // Lock bus until done
                            start   <= 1'b1;
                        end
                        REG_RN:    rn_r    <= byte_merge(rn_r, wb_dat_w, wb_sel);
                        REG_RM:    rm_r    <= byte_merge(rm_r, wb_dat_w, wb_sel);
                        REG_RS:    rs_r    <= byte_merge(rs_r, wb_dat_w, wb_sel);
                        REG_FLAGS: flags_r <= flags_word[FLAGS_LSB +: 4];
                        default: ;                 // RESULT, STATUS read only
                    endcase
                end
            end
        end
    end

    // Decoded instruction fields to the execute path
    assign op       = alu_op_e'(instr_r[OPC_MSB:OPC_LSB]);
    assign s        = instr_r[S_BIT];
    assign imm      = instr_r[IMM_BIT];
    assign op2      = instr_r[OP2_MSB:OP2_LSB];
    assign rn       = rn_r;
    assign rm       = rm_r;
    assign rs_amt   = rs_r[7:0];            // Upper Rs bits ignored
    assign flags_in = flags_r;

endmodule

`default_nettype wire

// ==== verilog/alu_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_shifter
    import alu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  alu_op_e     op,
    input  logic        s,
    input  logic        imm,
    input  op2_field_u  op2,
    input  logic [31:0] rn,
    input  logic [31:0] rm,
    input  logic [7:0]  rs_amt,
    input  nzcv_t       flags_in,
    output logic        valid,
    output alu_op_e     op_q,
    output logic        s_q,
    output logic [31:0] rn_q,
    output logic [31:0] shifter_out,
    output logic        shifter_carry,
    output nzcv_t       flags_q
);

    logic [7:0]  amt;                       // Register-form shift amount
    logic [32:0] lsl_ext;                   // Bit 32 is the carry out
    logic [32:0] lsr_ext;                   // Bit 0 is the carry out
    logic [32:0] asr_ext;
    logic [63:0] ror_dbl;
    logic [63:0] imm_dbl;
    logic [31:0] sh_val;
    logic        sh_c;

    assign amt     = op2.rg.reg_shift ? rs_amt : {3'b000, op2.rg.shift_imm};
    assign lsl_ext = {1'b0, rm} << amt[4:0];
    assign lsr_ext = {rm, 1'b0} >> amt[4:0];
    assign asr_ext = $signed({rm, 1'b0}) >>> amt[4:0];
    assign ror_dbl = {rm, rm} >> amt[4:0];  // Rotate via doubled word
    assign imm_dbl = {24'd0, op2.imm.imm8, 24'd0, op2.imm.imm8} >> {op2.imm.rot, 1'b0};

    // ============================================================
    // Operand 2 and shifter carry
    // ============================================================
    always_comb begin
        sh_val = rm;                        // Amount 0, no shift
        sh_c   = flags_in.c;
        if (imm) begin
            sh_val = imm_dbl[31:0];
            if (op2.imm.rot != 4'd0) begin
                sh_c = imm_dbl[31];
            end
        end else if (amt != 8'd0) begin
            case (op2.rg.stype)
                SH_LSL: begin
                    sh_val = (amt < 8'd32) ? lsl_ext[31:0] : 32'd0;
                    sh_c   = (amt < 8'd32) ? lsl_ext[32] : (amt == 8'd32) & rm[0];
                end
                SH_LSR: begin
                    sh_val = (amt < 8'd32) ? lsr_ext[32:1] : 32'd0;
                    sh_c   = (amt < 8'd32) ? lsr_ext[0] : (amt == 8'd32) & rm[31];
                end
                SH_ASR: begin
                    sh_val = (amt < 8'd32) ? asr_ext[32:1] : {32{rm[31]}};  // Saturates
                    sh_c   = (amt < 8'd32) ? asr_ext[0] : rm[31];
                end
                default: begin          // ROR by amount mod 32
                    sh_val = ror_dbl[31:0];
                    sh_c   = ror_dbl[31];   // Multiple of 32 gives Rm[31]
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= start;
        end
    end

    // Stage payload captured on issue
    always_ff @(posedge clk) begin
        if (start) begin
            op_q          <= op;
            s_q           <= s;
            rn_q          <= rn;
            shifter_out   <= sh_val;
            shifter_carry <= sh_c;
            flags_q       <= flags_in;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/alu_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_exec
    import alu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        valid,
    input  alu_op_e     op_q,
    input  logic        s_q,
    input  logic [31:0] rn_q,
    input  logic [31:0] shifter_out,
    input  logic        shifter_carry,
    input  nzcv_t       flags_q,
    output logic        done,
    output logic [31:0] result,
    output nzcv_t       flags_out
);

    logic        sub_op;                    // SUB or SBC
    logic [31:0] b_eff;                     // Operand 2, inverted for subtract
    logic        cy_in;
    logic [32:0] sum;
    logic        ovf;
    logic [31:0] res;
    logic        arith;
    logic        known;                     // Supported opcode
    nzcv_t       flags_nx;

    // ============================================================
    // Shared adder doing subtraction as Rn + ~B + carry
    // ============================================================
    assign sub_op = (op_q == OP_SUB) || (op_q == OP_SBC);
    assign b_eff  = sub_op ? ~shifter_out : shifter_out;

    always_comb begin
        case (op_q)
            OP_SUB:         cy_in = 1'b1;
            OP_ADC, OP_SBC: cy_in = flags_q.c;  // SBC borrows on C clear
            default:        cy_in = 1'b0;
        endcase
    end

    assign sum = {1'b0, rn_q} + {1'b0, b_eff} + {32'd0, cy_in};
    assign ovf = (rn_q[31] == b_eff[31]) && (sum[31] != rn_q[31]);  // Signed overflow

    always_comb begin
        res   = '0;                         // Unsupported gives 0
        arith = 1'b0;
        known = 1'b1;
        case (op_q)
            OP_ADD, OP_ADC, OP_SUB, OP_SBC: begin
                res   = sum[31:0];
                arith = 1'b1;
            end
            OP_AND:  res = rn_q & shifter_out;
            OP_EOR:  res = rn_q ^ shifter_out;
            OP_ORR:  res = rn_q | shifter_out;
            OP_BIC:  res = rn_q & ~shifter_out;
            OP_MOV:  res = shifter_out;
            default: known = 1'b0;
        endcase
    end

    // NZCV update under S
    always_comb begin
        flags_nx = flags_q;
        if (s_q && known) begin
            flags_nx.n = res[31];
            flags_nx.z = (res == 32'd0);
            flags_nx.c = arith ? sum[32] : shifter_carry;  // Inverted borrow on sub
            flags_nx.v = arith ? ovf : flags_q.v;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= valid;
        end
    end

    always_ff @(posedge clk) begin
        if (valid) begin
            result    <= res;
            flags_out <= flags_nx;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/alu_wb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_wb_top
    import alu_pkg::*;
    import alu_regmap_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  logic [WB_ADR_W-1:0] wb_adr,
    input  logic [31:0]         wb_dat_w,
    input  logic [3:0]          wb_sel,
    output logic [31:0]         wb_dat_r,
    output logic                wb_ack
);

    // Issue path
    logic        start;
    alu_op_e     op;
    logic        s;
    logic        imm;
    op2_field_u  op2;
    logic [31:0] rn;
    logic [31:0] rm;
    logic [7:0]  rs_amt;
    nzcv_t       flags_in;

    // Stage link
    logic        valid;
    alu_op_e     op_q;
    logic        s_q;
    logic [31:0] rn_q;
    logic [31:0] shifter_out;
    logic        shifter_carry;
    nzcv_t       flags_q;

    // Completion
    logic        done;
    logic [31:0] result;
    nzcv_t       flags_out;

    alu_regs alu_regs_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .start    (start),
        .op       (op),
        .s        (s),
        .imm      (imm),
        .op2      (op2),
        .rn       (rn),
        .rm       (rm),
        .rs_amt   (rs_amt),
        .flags_in (flags_in),
        .done     (done),
        .result   (result),
        .flags_out(flags_out)
    );

    alu_shifter alu_shifter_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .op           (op),
        .s            (s),
        .imm          (imm),
        .op2          (op2),
        .rn           (rn),
        .rm           (rm),
        .rs_amt       (rs_amt),
        .flags_in     (flags_in),
        .valid        (valid),
        .op_q         (op_q),
        .s_q          (s_q),
        .rn_q         (rn_q),
        .shifter_out  (shifter_out),
        .shifter_carry(shifter_carry),
        .flags_q      (flags_q)
    );

    alu_exec alu_exec_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid        (valid),
        .op_q         (op_q),
        .s_q          (s_q),
        .rn_q         (rn_q),
        .shifter_out  (shifter_out),
        .shifter_carry(shifter_carry),
        .flags_q      (flags_q),
        .done         (done),
        .result       (result),
        .flags_out    (flags_out)
    );

endmodule

`default_nettype wire

// ==== testbench/alu_wb_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_wb_asserts (
    input logic clk,
    input logic rst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic busy
);

    int fail_count = 0;                     // Read by the testbench at the end

    // ============================================================
    // Wishbone handshake
    // ============================================================
    ack_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else begin
            $error("ack raised without a pending cyc and stb");
            fail_count++;
        end

    ack_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else begin
            $error("ack held high for two cycles");
            fail_count++;
        end

    ack_not_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> !$past(busy))            // Access granted only when idle
        else begin
            $error("ack granted while an instruction was in flight");
            fail_count++;
        end

    // Write edge to completion edge is three clocks
    busy_three_cycles: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busy) |-> busy [*3] ##1 !busy)
        else begin
            $error("busy did not fall three cycles after it rose");
            fail_count++;
        end

endmodule

bind alu_regs alu_wb_asserts alu_wb_asserts_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_ack(wb_ack),
    .busy  (busy)
);

`default_nettype wire

// ==== testbench/tb_alu_wb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_alu_wb
    import alu_pkg::*;
    import alu_regmap_pkg::*;
();

    localparam int ACK_TIMEOUT = 50;        // Cycles before giving up on ack

    logic                clk;
    logic                rst_n;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    logic [WB_ADR_W-1:0] wb_adr;
    logic [31:0]         wb_dat_w;
    logic [3:0]          wb_sel;
    logic [31:0]         wb_dat_r;
    logic                wb_ack;

    alu_wb_top alu_wb_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_adr  (wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_sel  (wb_sel),
        .wb_dat_r(wb_dat_r),
        .wb_ack  (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;             // 20 ns period
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            stop_with_failure($sformatf("Fail %s expected %08h actual %08h", name, exp, act));
        end
    endtask

    // ============================================================
    // Bus tasks entered and left on a falling edge
    // ============================================================
    task automatic wait_ack(input logic [WB_ADR_W-1:0] adr);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > ACK_TIMEOUT) begin
                stop_with_failure($sformatf("No acknowledge arrived for address %02h", adr));
            end
        end while (!wb_ack);
        wb_cyc = 1'b0;                      // Drop request once acked
        wb_stb = 1'b0;
    endtask

    task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [31:0] data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        wb_sel   = 4'hF;
        wait_ack(adr);
        wb_we    = 1'b0;
    endtask

    task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [31:0] data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wb_sel = 4'hF;
        wait_ack(adr);
        data   = wb_dat_r;                  // Registered so stable at negedge
    endtask

    // Instruction word builders
    function automatic logic [31:0] enc_reg(input logic [3:0] opc, input logic s_bit,
        input logic [4:0] sh_amt, input logic [1:0] sh_type, input logic from_rs);
        return {6'd0, 1'b0, opc, s_bit, 8'd0, sh_amt, sh_type, from_rs, 4'd0};
    endfunction

    function automatic logic [31:0] enc_imm(input logic [3:0] opc, input logic s_bit,
        input logic [3:0] rot, input logic [7:0] imm8);
        return {6'd0, 1'b1, opc, s_bit, 8'd0, rot, imm8};
    endfunction

    // ============================================================
    // Reference model returning {nzcv, result}
    // ============================================================
    function automatic logic [35:0] model_alu(input logic [31:0] instr, input logic [31:0] rn,
        input logic [31:0] rm, input logic [31:0] rs, input logic [3:0] nzcv);
        logic [7:0]  amt;
        logic [4:0]  r;
        logic [31:0] b;
        logic [31:0] k;
        logic        sc;
        logic [31:0] res;
        logic [32:0] wide;
        logic        c_out;
        logic        v_out;
        logic        known;
        logic [3:0]  f;
        b     = rm;
        sc    = nzcv[1];                    // Incoming C
        known = 1'b1;
        if (instr[25]) begin
            k = {24'd0, instr[7:0]};
            r = {instr[11:8], 1'b0};
            b = (r == 5'd0) ? k : ((k >> r) | (k << (32 - r)));
            if (instr[11:8] != 4'd0) sc = b[31];
        end else begin
            amt = instr[4] ? rs[7:0] : {3'd0, instr[11:7]};
            if (amt != 8'd0) begin
                case (instr[6:5])
                    2'd0: begin             // LSL
                        b  = (amt < 32) ? rm << amt : 32'd0;
                        sc = (amt < 32) ? rm[32 - amt] : ((amt == 32) ? rm[0] : 1'b0);
                    end
                    2'd1: begin             // LSR
                        b  = (amt < 32) ? rm >> amt : 32'd0;
                        sc = (amt < 32) ? rm[amt - 1] : ((amt == 32) ? rm[31] : 1'b0);
                    end
                    2'd2: begin             // ASR saturates past 31
                        b  = (amt < 32) ? 32'($signed(rm) >>> amt) : {32{rm[31]}};
                        sc = (amt < 32) ? rm[amt - 1] : rm[31];
                    end
                    default: begin          // ROR
                        r  = amt[4:0];
                        b  = (r == 5'd0) ? rm : ((rm >> r) | (rm << (32 - r)));
                        sc = b[31];
                    end
                endcase
            end
        end
        c_out = sc;
        v_out = nzcv[0];
        case (instr[24:21])
            OP_ADD, OP_ADC: begin
                wide  = {1'b0, rn} + {1'b0, b} + ((instr[24:21] == OP_ADC) ? nzcv[1] : 1'b0);
                res   = wide[31:0];
                c_out = wide[32];
                v_out = (rn[31] == b[31]) && (res[31] != rn[31]);
            end
            OP_SUB, OP_SBC: begin
                wide  = {1'b0, b} + ((instr[24:21] == OP_SBC) ? !nzcv[1] : 1'b0);
                res   = rn - wide[31:0];
                c_out = ({1'b0, rn} >= wide);          // No borrow
                v_out = (rn[31] != b[31]) && (res[31] != rn[31]);
            end
            OP_AND:  res = rn & b;
            OP_EOR:  res = rn ^ b;
            OP_ORR:  res = rn | b;
            OP_BIC:  res = rn & ~b;
            OP_MOV:  res = b;
            default: begin
                res   = 32'd0;
                known = 1'b0;
            end
        endcase
        f = (instr[20] && known) ? {res[31], res == 32'd0, c_out, v_out} : nzcv;
        return {f, res};
    endfunction

    // Load operands, issue, read back straight away and compare
    task automatic run_instr(input string name, input logic [31:0] instr, input logic [31:0] rn,
        input logic [31:0] rm, input logic [31:0] rs, input logic [3:0] nzcv);
        logic [35:0] exp;
        logic [31:0] got;
        exp = model_alu(instr, rn, rm, rs, nzcv);
        wb_write(REG_RN, rn);
        wb_write(REG_RM, rm);
        wb_write(REG_RS, rs);
        wb_write(REG_FLAGS, {nzcv, 28'd0});
        wb_write(REG_INSTR, instr);
        wb_read(REG_RESULT, got);           // Stalls until done
        check_eq({name, " result"}, exp[31:0], got);
        wb_read(REG_FLAGS, got);
        check_eq({name, " flags"}, {exp[35:32], 28'd0}, got);
    endtask

    // ============================================================
    // Directed tests
    // ============================================================
    task automatic test_reset();
        logic [31:0] got;
        wb_read(REG_STATUS, got);
        check_eq("reset status", 32'd0, got);
        wb_read(REG_FLAGS, got);
        check_eq("reset flags", 32'd0, got);
        wb_read(REG_RESULT, got);
        check_eq("reset result", 32'd0, got);
    endtask

    task automatic test_arith();
        run_instr("add carry zero", enc_reg(OP_ADD, 1, 0, SH_LSL, 0),
                  32'hFFFF_FFFF, 32'd1, 0, 4'b0000);
        run_instr("add overflow", enc_reg(OP_ADD, 1, 0, SH_LSL, 0), 32'h7FFF_FFFF, 32'd1, 0, 4'b0000);
        run_instr("adc carry in", enc_reg(OP_ADC, 1, 0, SH_LSL, 0), 32'd1, 32'd2, 0, 4'b0010);
        run_instr("adc wrap", enc_reg(OP_ADC, 1, 0, SH_LSL, 0), 32'hFFFF_FFFE, 32'd1, 0, 4'b0010);
        run_instr("sub borrow", enc_reg(OP_SUB, 1, 0, SH_LSL, 0), 32'd1, 32'd2, 0, 4'b0000);
        run_instr("sub zero", enc_reg(OP_SUB, 1, 0, SH_LSL, 0), 32'd5, 32'd5, 0, 4'b1001);
        run_instr("sbc c clear", enc_reg(OP_SBC, 1, 0, SH_LSL, 0), 32'd10, 32'd3, 0, 4'b0000);
        run_instr("sbc overflow", enc_reg(OP_SBC, 1, 0, SH_LSL, 0), 32'h8000_0000, 32'd1, 0, 4'b0010);
    endtask

    task automatic test_shifts();
        run_instr("and lsl 4", enc_reg(OP_AND, 1, 4, SH_LSL, 0),
                  32'hFFFF_0FF0, 32'hF123_4567, 0, 4'b0000);
        run_instr("orr lsr 1", enc_reg(OP_ORR, 1, 1, SH_LSR, 0),
                  32'h0000_0100, 32'h0000_0003, 0, 4'b0000);
        run_instr("eor asr 31", enc_reg(OP_EOR, 1, 31, SH_ASR, 0),
                  32'h1234_5678, 32'h8000_0000, 0, 4'b0000);
        run_instr("bic ror 8", enc_reg(OP_BIC, 1, 8, SH_ROR, 0),
                  32'hFFFF_FFFF, 32'h0000_00F1, 0, 4'b0000);
        run_instr("mov lsr imm 0", enc_reg(OP_MOV, 1, 0, SH_LSR, 0), 0, 32'h8000_0001, 0, 4'b0010);
        run_instr("mov lsl rs 0", enc_reg(OP_MOV, 1, 0, SH_LSL, 1),
                  0, 32'h0000_0001, 32'h100, 4'b0010);
        run_instr("mov lsl rs 32", enc_reg(OP_MOV, 1, 0, SH_LSL, 1), 0, 32'h0000_0001, 32, 4'b0000);
        run_instr("mov lsr rs 32", enc_reg(OP_MOV, 1, 0, SH_LSR, 1), 0, 32'h8000_0000, 32, 4'b0000);
        run_instr("mov lsl rs 40", enc_reg(OP_MOV, 1, 0, SH_LSL, 1), 0, 32'hFFFF_FFFF, 40, 4'b0010);
        run_instr("mov lsr rs 40", enc_reg(OP_MOV, 1, 0, SH_LSR, 1), 0, 32'hFFFF_FFFF, 40, 4'b0010);
        run_instr("mov asr rs 32", enc_reg(OP_MOV, 1, 0, SH_ASR, 1), 0, 32'h8000_0000, 32, 4'b0000);
        run_instr("mov asr rs 40", enc_reg(OP_MOV, 1, 0, SH_ASR, 1), 0, 32'h7FFF_FFFF, 40, 4'b0010);
        run_instr("mov ror rs 32", enc_reg(OP_MOV, 1, 0, SH_ROR, 1), 0, 32'h8000_00F0, 32, 4'b0000);
        run_instr("mov ror rs 40", enc_reg(OP_MOV, 1, 0, SH_ROR, 1), 0, 32'h0000_0080, 40, 4'b0000);
        run_instr("orr ror rs 3", enc_reg(OP_ORR, 1, 0, SH_ROR, 1),
                  32'h10, 32'h0000_0005, 3, 4'b0000);
    endtask

    task automatic test_immediate();
        run_instr("imm rot 0", enc_imm(OP_MOV, 1, 4'd0, 8'hFF), 0, 0, 0, 4'b0010);
        run_instr("imm rot 1", enc_imm(OP_MOV, 1, 4'd1, 8'h03), 0, 0, 0, 4'b0000);
        run_instr("imm rot 4", enc_imm(OP_ORR, 1, 4'd4, 8'hAB), 32'h1, 0, 0, 4'b0010);
        run_instr("imm rot 15", enc_imm(OP_AND, 1, 4'd15, 8'h81), 32'hFFFF_FFFF, 0, 0, 4'b0010);
        run_instr("imm sub", enc_imm(OP_SUB, 1, 4'd12, 8'h01), 32'h0001_0000, 0, 0, 4'b0000);
    endtask

    task automatic test_s_clear();
        logic [31:0] got;
        run_instr("add s clear", enc_reg(OP_ADD, 0, 0, SH_LSL, 0), 32'hFFFF_FFFF, 32'd1, 0, 4'b1010);
        run_instr("mov s clear", enc_imm(OP_MOV, 0, 4'd1, 8'h03), 0, 0, 0, 4'b0101);
        run_instr("prior result", enc_reg(OP_ORR, 1, 0, SH_LSL, 0), 32'h5A5A_0000, 32'h1, 0, 4'b0000);
        // RESULT is nonzero here, so a zero read proves the stall
        run_instr("unsupported op", enc_reg(4'd3, 1, 0, SH_LSL, 0), 32'd7, 32'd9, 0, 4'b0110);
        wb_read(REG_STATUS, got);
        check_eq("status after done", 32'd0, got);
    endtask

    task automatic test_random();
        logic [3:0]  ops [9] = '{OP_AND, OP_EOR, OP_SUB, OP_ADD, OP_ADC,
                                 OP_SBC, OP_ORR, OP_MOV, OP_BIC};
        logic [31:0] instr;
        logic [31:0] rs;
        for (int i = 0; i < 40; i++) begin
            instr        = $urandom;        // Ignored bits stay random
            instr[24:21] = ops[$urandom_range(0, 8)];
            rs           = ($urandom & 32'hFFFF_FF00) | $urandom_range(0, 40);
            run_instr($sformatf("random %0d", i), instr, $urandom, $urandom, rs, 4'($urandom));
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        wb_sel   = 4'h0;
        void'($urandom(4));
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        test_reset();
        test_arith();
        test_shifts();
        test_immediate();
        test_s_clear();
        test_random();
        repeat (2) @(negedge clk);          // Let the last assertions settle
        if (alu_wb_top_inst.alu_regs_inst.alu_wb_asserts_inst.fail_count != 0) begin
            stop_with_failure("A bus handshake assertion failed during the run");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/alu_pkg.sv
verilog/alu_regmap_pkg.sv
verilog/alu_regs.sv
verilog/alu_shifter.sv
verilog/alu_exec.sv
verilog/alu_wb_top.sv
testbench/alu_wb_asserts.sv
testbench/tb_alu_wb.sv

// ==== Bender.yml ====
package:
  name: alu_wb

sources:
  - verilog/alu_pkg.sv
  - verilog/alu_regmap_pkg.sv
  - verilog/alu_regs.sv
  - verilog/alu_shifter.sv
  - verilog/alu_exec.sv
  - verilog/alu_wb_top.sv
  - target: test
    files:
      - testbench/alu_wb_asserts.sv
      - testbench/tb_alu_wb.sv
